//--- verilog/udma_pkg.sv
// Micro-DMA shared definitions
`default_nettype none

package udma_pkg;

    localparam int NUM_CH = 4;
    localparam int ADDR_W = 24;

    typedef logic [31:0]       reg_word_t;
    typedef logic [15:0]       dma_count_t;
    typedef logic [7:0]        dma_mode_t;
    typedef logic [15:0]       nest_t;
    typedef logic [1:0]        ch_sel_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [1:0]        xfer_size_t;

    // Address update mode, bits 4:2 of the mode register
    localparam logic [2:0] MODE_DST_INC = 3'd0;
    localparam logic [2:0] MODE_DST_DEC = 3'd1;
    localparam logic [2:0] MODE_SRC_INC = 3'd2;
    localparam logic [2:0] MODE_SRC_DEC = 3'd3;
    localparam logic [2:0] MODE_FIXED   = 3'd4;

    // Transfer size, bits 1:0 of the mode register
    localparam xfer_size_t SIZE_BYTE = 2'd0;
    localparam xfer_size_t SIZE_WORD = 2'd1;
    localparam xfer_size_t SIZE_QUAD = 2'd2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_UPDATE
    } engine_state_t;

    typedef struct packed {
        reg_word_t  src;
        reg_word_t  dst;
        dma_count_t count;
        dma_mode_t  mode;
    } chan_cfg_t;

    typedef struct packed {
        logic       valid;
        ch_sel_t    ch;
        reg_word_t  src;
        reg_word_t  dst;
        dma_count_t count;
    } chan_upd_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        mem_addr_t  addr;
        xfer_size_t size;
        reg_word_t  wdata;
    } mem_req_t;

    typedef struct packed {
        logic      ack;
        reg_word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/udma_regs.sv
// Micro-DMA channel registers
`timescale 1ns/1ns
`default_nettype none

module udma_regs import udma_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  reg_word_t              din,
    input  logic [5:0]             addr,
    input  logic                   qs,
    input  logic                   ws,
    input  logic                   bs,
    input  logic                   we,
    input  logic                   nstinc,
    input  logic                   nstdec,
    input  chan_upd_t              upd,
    output reg_word_t              dout,
    output chan_cfg_t [NUM_CH-1:0] cfg
);

    logic      quad_we;
    logic      word_we;
    logic      byte_we;
    logic      src_hit;
    logic      dst_hit;
    logic      cnt_hit;
    ch_sel_t   ch;
    nest_t     nest;
    reg_word_t rd_data;

    assign quad_we = we & qs;
    assign word_we = we & ws;
    assign byte_we = we & bs;
    assign ch      = addr[3:2];

    // CPU writes that touch a register the engine also updates
    assign src_hit = (addr[5:4] == 2'd0) && (quad_we | word_we | byte_we);
    assign dst_hit = (addr[5:4] == 2'd1) && (quad_we | word_we | byte_we);
    assign cnt_hit = (addr[5:4] == 2'd2) && (quad_we | ((word_we | byte_we) & ~addr[1]));

    always_comb begin
        rd_data = '0;
        case (addr[5:4])
            2'd0: rd_data = cfg[ch].src;
            2'd1: rd_data = cfg[ch].dst;
            2'd2: begin
                if (addr[1]) begin
                    rd_data = {24'd0, cfg[ch].mode};
                end else begin
                    rd_data = {8'd0, cfg[ch].mode, cfg[ch].count};
                end
            end
            default: begin
                if (addr[3:0] == 4'hc) begin
                    rd_data = {16'd0, nest}; // Nesting counter at 0x3C
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg  <= '0;
            nest <= '0;
            dout <= '0;
        end else if (cen) begin
            dout <= rd_data;

            if (nstdec) begin
                nest <= nest - 1'b1; // Decrement wins over increment
            end else if (nstinc) begin
                nest <= nest + 1'b1;
            end

            // Engine write-back, skipped where the CPU writes
            if (upd.valid) begin
                if (!(src_hit && ch == upd.ch)) begin
                    cfg[upd.ch].src <= upd.src;
                end
                if (!(dst_hit && ch == upd.ch)) begin
                    cfg[upd.ch].dst <= upd.dst;
                end
                if (!(cnt_hit && ch == upd.ch)) begin
                    cfg[upd.ch].count <= upd.count;
                end
            end

            case (addr[5:4])
                2'd0: begin
                    if (quad_we) cfg[ch].src <= din;
                    if (word_we) cfg[ch].src[{addr[1], 4'd0} +: 16] <= din[15:0];
                    if (byte_we) cfg[ch].src[{addr[1:0], 3'd0} +: 8] <= din[7:0];
                end
                2'd1: begin
                    if (quad_we) cfg[ch].dst <= din;
                    if (word_we) cfg[ch].dst[{addr[1], 4'd0} +: 16] <= din[15:0];
                    if (byte_we) cfg[ch].dst[{addr[1:0], 3'd0} +: 8] <= din[7:0];
                end
                2'd2: begin
                    if (quad_we) begin
                        {cfg[ch].mode, cfg[ch].count} <= din[23:0];
                    end
                    if (word_we) begin
                        if (addr[1]) begin
                            cfg[ch].mode <= din[7:0];
                        end else begin
                            cfg[ch].count <= din[15:0];
                        end
                    end
                    if (byte_we) begin
                        if (!addr[1]) begin
                            cfg[ch].count[(addr[0] ? 8 : 0) +: 8] <= din[7:0];
                        end else if (!addr[0]) begin
                            cfg[ch].mode <= din[7:0]; // Mode has no high byte
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/udma_engine.sv
// Micro-DMA transfer engine
`timescale 1ns/1ns
`default_nettype none

module udma_engine import udma_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [NUM_CH-1:0]      dma_req,
    input  chan_cfg_t [NUM_CH-1:0] cfg,
    input  mem_rsp_t               mem_rsp,
    output mem_req_t               mem_req,
    output chan_upd_t              upd,
    output logic [NUM_CH-1:0]      dma_done,
    output logic                   busy
);

    engine_state_t       state;
    logic [NUM_CH-1:0]   pending;
    logic [NUM_CH-1:0]   cur_bit;
    ch_sel_t             cur_ch;
    ch_sel_t             pick;
    chan_cfg_t           cur_cfg;  // Channel snapshot taken at start
    reg_word_t           data;
    reg_word_t           step;
    reg_word_t           next_src;
    reg_word_t           next_dst;
    dma_count_t          next_count;
    xfer_size_t          size;

    // Lowest pending channel wins
    always_comb begin
        pick = '0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (pending[i]) pick = ch_sel_t'(i);
        end
    end

    always_comb begin
        case (xfer_size_t'(cur_cfg.mode[1:0]))
            SIZE_BYTE: begin
                size = SIZE_BYTE;
                step = 32'd1;
            end
            SIZE_WORD: begin
                size = SIZE_WORD;
                step = 32'd2;
            end
            default: begin
                size = SIZE_QUAD; // Code 3 acts as quad
                step = 32'd4;
            end
        endcase
    end

    always_comb begin
        next_src = cur_cfg.src;
        next_dst = cur_cfg.dst;
        case (cur_cfg.mode[4:2])
            MODE_DST_INC: next_dst = cur_cfg.dst + step;
            MODE_DST_DEC: next_dst = cur_cfg.dst - step;
            MODE_SRC_INC: next_src = cur_cfg.src + step;
            MODE_SRC_DEC: next_src = cur_cfg.src - step;
            MODE_FIXED:   ;
            default:      ; // Unused codes keep both addresses
        endcase
    end

    assign next_count = cur_cfg.count - 1'b1; // Wraps to 0xFFFF
    assign cur_bit    = NUM_CH'(1) << cur_ch;
    assign busy       = (state != ST_IDLE);

    always_comb begin
        mem_req.valid = (state == ST_READ) || (state == ST_WRITE);
        mem_req.we    = (state == ST_WRITE);
        mem_req.addr  = (state == ST_WRITE) ? cur_cfg.dst[ADDR_W-1:0] : cur_cfg.src[ADDR_W-1:0];
        mem_req.size  = size;
        mem_req.wdata = data;
    end

    always_comb begin
        upd.valid = (state == ST_UPDATE);
        upd.ch    = cur_ch;
        upd.src   = next_src;
        upd.dst   = next_dst;
        upd.count = next_count;
    end

    assign dma_done = (state == ST_UPDATE && next_count == '0) ? cur_bit : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            pending <= '0;
            cur_ch  <= '0;
        end else if (cen) begin
            // A new pulse outranks the clear of the served channel
            pending <= (pending & ~((state == ST_UPDATE) ? cur_bit : '0)) | dma_req;
            case (state)
                ST_IDLE: begin
                    if (|pending) begin
                        state  <= ST_READ;
                        cur_ch <= pick;
                    end
                end
                ST_READ:   if (mem_rsp.ack) state <= ST_WRITE;
                ST_WRITE:  if (mem_rsp.ack) state <= ST_UPDATE;
                ST_UPDATE: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (state == ST_IDLE && |pending) cur_cfg <= cfg[pick];
            if (state == ST_READ && mem_rsp.ack) data <= mem_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/udma_top.sv
// Micro-DMA top level
`timescale 1ns/1ns
`default_nettype none

module udma_top import udma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  reg_word_t         din,
    input  logic [5:0]        addr,
    input  logic              qs,
    input  logic              ws,
    input  logic              bs,
    input  logic              we,
    input  logic              nstinc,
    input  logic              nstdec,
    input  logic [NUM_CH-1:0] dma_req,
    input  mem_rsp_t          mem_rsp,
    output reg_word_t         dout,
    output mem_req_t          mem_req,
    output logic [NUM_CH-1:0] dma_done,
    output logic              busy
);

    chan_cfg_t [NUM_CH-1:0] cfg;  // Register contents to the engine
    chan_upd_t              upd;  // Write-back from the engine

    udma_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .qs     (qs),
        .ws     (ws),
        .bs     (bs),
        .we     (we),
        .nstinc (nstinc),
        .nstdec (nstdec),
        .upd    (upd),
        .dout   (dout),
        .cfg    (cfg)
    );

    udma_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .dma_req  (dma_req),
        .cfg      (cfg),
        .mem_rsp  (mem_rsp),
        .mem_req  (mem_req),
        .upd      (upd),
        .dma_done (dma_done),
        .busy     (busy)
    );

endmodule

`default_nettype wire

//--- dv/udma_props.sv
// Micro-DMA engine assertions
`timescale 1ns/1ns
`default_nettype none

module udma_props import udma_pkg::*; (
    input logic              clk,
    input logic              rst,
    input mem_req_t          mem_req,
    input mem_rsp_t          mem_rsp,
    input chan_upd_t         upd,
    input logic [NUM_CH-1:0] dma_done,
    input logic              busy
);

    // Request held until the memory acks
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && !mem_rsp.ack) |=> $stable(mem_req))
        else $error("mem_req changed while waiting for ack");

    // Done comes only in the cycle after the write ack
    a_done_update: assert property (@(posedge clk) disable iff (rst)
        (dma_done != '0) |-> ($onehot(dma_done)
                              && $past(mem_req.valid && mem_req.we && mem_rsp.ack)))
        else $error("dma_done not one-hot right after a write ack");

    a_upd_busy: assert property (@(posedge clk) disable iff (rst)
        upd.valid |-> (busy && $past(mem_req.valid && mem_req.we && mem_rsp.ack)))
        else $error("upd.valid not right after a write ack while busy");

endmodule

bind udma_engine udma_props u_props (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .upd      (upd),
    .dma_done (dma_done),
    .busy     (busy)
);

`default_nettype wire

//--- dv/udma_tb.sv
// Micro-DMA testbench
`timescale 1ns/1ns
`default_nettype none

module udma_tb import udma_pkg::*; ();

    localparam int CLK_HALF   = 20;
    localparam int N_REG_OPS  = 120;
    localparam int N_NEST_OPS = 80;
    localparam int N_XFERS    = 40;
    localparam int N_PRIO     = 12;
    localparam int N_CEN_OPS  = 20;
    localparam int OP_CYCLES  = 40;  // Setup, slowest transfer and read-back
    localparam int TOTAL_OPS  = 10 + N_REG_OPS + N_NEST_OPS + N_XFERS + 2
                                + N_PRIO * NUM_CH + 2 * N_CEN_OPS;

    logic              clk = 1'b0;
    logic              rst;
    logic              cen;
    reg_word_t         din;
    logic [5:0]        addr;
    logic              qs;
    logic              ws;
    logic              bs;
    logic              we;
    logic              nstinc;
    logic              nstdec;
    logic [NUM_CH-1:0] dma_req;
    mem_rsp_t          mem_rsp;
    reg_word_t         dout;
    mem_req_t          mem_req;
    logic [NUM_CH-1:0] dma_done;
    logic              busy;

    integer            seed = 72912;
    int                delay = -1;
    reg_word_t         m_src   [NUM_CH];
    reg_word_t         m_dst   [NUM_CH];
    dma_count_t        m_count [NUM_CH];
    dma_mode_t         m_mode  [NUM_CH];
    nest_t             m_nest;
    logic [7:0]        mem [mem_addr_t];       // Sparse byte memory
    logic [7:0]        exp_bytes [NUM_CH][4];  // Source bytes per channel
    mem_addr_t         rd_log [$];             // Read addresses in bus order
    logic [NUM_CH-1:0] done_q [$];

    udma_top UUT (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .din      (din),
        .addr     (addr),
        .qs       (qs),
        .ws       (ws),
        .bs       (bs),
        .we       (we),
        .nstinc   (nstinc),
        .nstdec   (nstdec),
        .dma_req  (dma_req),
        .mem_rsp  (mem_rsp),
        .dout     (dout),
        .mem_req  (mem_req),
        .dma_done (dma_done),
        .busy     (busy)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_with_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(string what, reg_word_t exp, reg_word_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s expected %h got %h", $time, what, exp, got);
            stop_with_fail();
        end
    endtask

    task automatic check_count(string what, dma_count_t exp, dma_count_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s count expected %h got %h", $time, what, exp, got);
            stop_with_fail();
        end
    endtask

    task automatic check_nest(nest_t exp, nest_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: nesting counter expected %h got %h", $time, exp, got);
            stop_with_fail();
        end
    endtask

    task automatic check_done(string what, logic [NUM_CH-1:0] exp, logic [NUM_CH-1:0] got);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s done expected %b got %b", $time, what, exp, got);
            stop_with_fail();
        end
    endtask

    task automatic check_mem_byte(mem_addr_t a, logic [7:0] exp);
        if (!mem.exists(a) || mem[a] !== exp) begin
            $display("[FAIL] %0t ns: memory byte %h expected %h got %h", $time, a, exp,
                     mem.exists(a) ? mem[a] : 8'hxx);
            stop_with_fail();
        end
    endtask

    // Unwritten bytes read back a pattern of the full address
    function automatic logic [7:0] mem_byte(mem_addr_t a);
        if (mem.exists(a)) return mem[a];
        return a[7:0] ^ a[15:8] ^ ~a[23:16];
    endfunction

    function automatic int size_bytes(dma_mode_t m);
        case (m[1:0])
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic reg_word_t merge_write(reg_word_t old, int kind, logic [1:0] lo,
                                              reg_word_t d);
        reg_word_t r;
        r = old;
        case (kind)
            0:       r[8*lo +: 8] = d[7:0];
            1:       r[16*lo[1] +: 16] = d[15:0];
            default: r = d;
        endcase
        return r;
    endfunction

    // Register map of the CPU side; kind 0 byte, 1 word, 2 quad
    function automatic void model_write(int kind, logic [5:0] a, reg_word_t d);
        int c;
        c = a[3:2];
        case (a[5:4])
            2'd0: m_src[c] = merge_write(m_src[c], kind, a[1:0], d);
            2'd1: m_dst[c] = merge_write(m_dst[c], kind, a[1:0], d);
            2'd2: begin
                if (kind == 2) begin
                    m_mode[c]  = d[23:16];
                    m_count[c] = d[15:0];
                end else if (kind == 1) begin
                    if (a[1]) m_mode[c] = d[7:0];
                    else m_count[c] = d[15:0];
                end else if (!a[1]) begin
                    m_count[c][8*a[0] +: 8] = d[7:0];
                end else if (!a[0]) begin
                    m_mode[c] = d[7:0];
                end
            end
            default: ;
        endcase
    endfunction

    // One transfer on the model, returns the expected done vector
    function automatic logic [NUM_CH-1:0] model_transfer(int ch);
        reg_word_t         step;
        logic [NUM_CH-1:0] done_v;
        step = size_bytes(m_mode[ch]);
        done_v = '0;
        case (m_mode[ch][4:2])
            MODE_DST_INC: m_dst[ch] = m_dst[ch] + step;
            MODE_DST_DEC: m_dst[ch] = m_dst[ch] - step;
            MODE_SRC_INC: m_src[ch] = m_src[ch] + step;
            MODE_SRC_DEC: m_src[ch] = m_src[ch] - step;
            default: ;
        endcase
        m_count[ch] = m_count[ch] - 16'd1;
        if (m_count[ch] == 16'd0) done_v[ch] = 1'b1;
        return done_v;
    endfunction

    // Regions apart per channel and direction, unaligned low bits
    function automatic reg_word_t make_addr(logic region, int ch);
        reg_word_t r;
        r = $random(seed);
        return {r[31:24], region, 2'(ch), r[20:4], 1'b0, r[2:0]};
    endfunction

    function automatic logic [NUM_CH-1:0] done_seen();
        logic [NUM_CH-1:0] v;
        v = '0;
        foreach (done_q[i]) v = v | done_q[i];
        return v;
    endfunction

    task automatic cpu_write(int kind, logic [5:0] a, reg_word_t d);
        @(posedge clk);
        addr <= a;
        din  <= d;
        we   <= 1'b1;
        bs   <= (kind == 0);
        ws   <= (kind == 1);
        qs   <= (kind == 2);
        @(posedge clk);
        we <= 1'b0;
        bs <= 1'b0;
        ws <= 1'b0;
        qs <= 1'b0;
        if (cen) model_write(kind, a, d);
    endtask

    task automatic cpu_read(logic [5:0] a, output reg_word_t d);
        @(posedge clk);
        addr <= a;
        @(posedge clk);
        @(negedge clk);  // dout registered at the edge before
        d = dout;
    endtask

    task automatic nest_strobe(logic inc, logic dec);
        @(posedge clk);
        nstinc <= inc;
        nstdec <= dec;
        @(posedge clk);
        nstinc <= 1'b0;
        nstdec <= 1'b0;
        if (cen) m_nest = dec ? m_nest - 16'd1 : (inc ? m_nest + 16'd1 : m_nest);
    endtask

    task automatic verify_all();
        reg_word_t  v;
        logic [1:0] c;
        string      tag;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            c   = ch[1:0];
            tag = $sformatf("ch%0d", ch);
            cpu_read({2'd0, c, 2'd0}, v);
            check_word({tag, " src"}, m_src[ch], v);
            cpu_read({2'd1, c, 2'd0}, v);
            check_word({tag, " dst"}, m_dst[ch], v);
            cpu_read({2'd2, c, 2'd0}, v);
            check_count(tag, m_count[ch], v[15:0]);
            cpu_read({2'd2, c, 2'd2}, v);
            check_word({tag, " mode"}, {24'd0, m_mode[ch]}, v);
        end
        cpu_read(6'h3c, v);
        check_nest(m_nest, v[15:0]);
        cpu_read(6'h30, v);
        check_word("unmapped read", 32'd0, v);
    endtask

    task automatic setup_random(int ch, dma_count_t cnt);
        logic [1:0] c;
        dma_mode_t  mode;
        c    = ch[1:0];
        mode = $random(seed);  // Covers unused mode and size codes too
        cpu_write(2, {2'd0, c, 2'd0}, make_addr(1'b0, ch));
        cpu_write(2, {2'd1, c, 2'd0}, make_addr(1'b1, ch));
        cpu_write(2, {2'd2, c, 2'd0}, {8'd0, mode, cnt});
    endtask

    task automatic fill_source(int ch);
        for (int i = 0; i < size_bytes(m_mode[ch]); i++) begin
            exp_bytes[ch][i] = $random(seed);
            mem[m_src[ch][23:0] + mem_addr_t'(i)] = exp_bytes[ch][i];
        end
    endtask

    task automatic check_copy(int ch, reg_word_t dst);
        for (int i = 0; i < size_bytes(m_mode[ch]); i++) begin
            check_mem_byte(dst[23:0] + mem_addr_t'(i), exp_bytes[ch][i]);
        end
    endtask

    task automatic pulse_request(logic [NUM_CH-1:0] mask);
        @(posedge clk);
        dma_req <= mask;
        @(posedge clk);
        dma_req <= '0;
    endtask

    // Busy drops for a cycle between back-to-back transfers
    task automatic wait_transfers(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge busy);
            @(negedge busy);
        end
    endtask

    task automatic do_transfer(int ch);
        reg_word_t         old_dst;
        logic [NUM_CH-1:0] mask;
        mask = '0;
        mask[ch] = 1'b1;
        fill_source(ch);
        old_dst = m_dst[ch];
        done_q.delete();
        pulse_request(mask);
        wait_transfers(1);
        if (done_q.size() > 1) begin
            $display("More than one done pulse seen for a single transfer");
            stop_with_fail();
        end
        check_done($sformatf("ch%0d", ch), model_transfer(ch), done_seen());
        check_copy(ch, old_dst);
        verify_all();
    endtask

    task automatic priority_round();
        logic [NUM_CH-1:0] mask;
        logic [NUM_CH-1:0] exp_done;
        mem_addr_t         exp_order [$];
        reg_word_t         old_dst [NUM_CH];
        mask = $random(seed);
        if ($countones(mask) < 2) mask = mask | 4'b1010;
        exp_done = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (mask[ch]) begin
                setup_random(ch, dma_count_t'($random(seed)));
                fill_source(ch);
                exp_order.push_back(m_src[ch][23:0]);  // Lowest channel first
                old_dst[ch] = m_dst[ch];
            end
        end
        rd_log.delete();
        done_q.delete();
        pulse_request(mask);
        wait_transfers(exp_order.size());
        if (rd_log.size() != exp_order.size()) begin
            $display("Number of memory reads differs from the channels requested");
            stop_with_fail();
        end
        foreach (exp_order[i]) check_word("service order", {8'd0, exp_order[i]}, {8'd0, rd_log[i]});
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (mask[ch]) begin
                exp_done = exp_done | model_transfer(ch);
                check_copy(ch, old_dst[ch]);
            end
        end
        check_done("priority round", exp_done, done_seen());
        verify_all();
    endtask

    // Memory with 0 to 3 cycles of latency per access
    initial begin : mem_model
        int        n;
        reg_word_t rd;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            mem_rsp.ack <= 1'b0;
            if (!rst && cen && mem_req.valid && !mem_rsp.ack) begin
                if (delay < 0) delay = $random(seed) & 3;
                if (delay == 0) begin
                    n  = (mem_req.size == SIZE_BYTE) ? 1 : ((mem_req.size == SIZE_WORD) ? 2 : 4);
                    rd = '0;
                    for (int i = 0; i < n; i++) begin
                        if (mem_req.we) begin
                            mem[mem_req.addr + mem_addr_t'(i)] = mem_req.wdata[8*i +: 8];
                        end else begin
                            rd[8*i +: 8] = mem_byte(mem_req.addr + mem_addr_t'(i));
                        end
                    end
                    if (!mem_req.we) rd_log.push_back(mem_req.addr);
                    mem_rsp.rdata <= rd;
                    mem_rsp.ack   <= 1'b1;
                    delay = -1;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && dma_done != '0) done_q.push_back(dma_done);
    end

    initial begin : watchdog
        #(longint'(TOTAL_OPS) * OP_CYCLES * 2 * 2 * CLK_HALF);
        $display("Watchdog expired, the test did not finish in time");
        stop_with_fail();
    end

    initial begin : stimulus
        int        kind;
        reg_word_t r;
        rst     = 1'b1;
        cen     = 1'b1;
        din     = '0;
        addr    = '0;
        qs      = 1'b0;
        ws      = 1'b0;
        bs      = 1'b0;
        we      = 1'b0;
        nstinc  = 1'b0;
        nstdec  = 1'b0;
        dma_req = '0;
        m_nest  = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            m_src[ch]   = '0;
            m_dst[ch]   = '0;
            m_count[ch] = '0;
            m_mode[ch]  = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        verify_all();  // Reset values

        for (int i = 0; i < N_REG_OPS; i++) begin
            kind = $unsigned($random(seed)) % 3;
            r    = $random(seed);
            cpu_write(kind, r[5:0], $random(seed));
            if (i % 16 == 15) verify_all();
        end
        verify_all();

        for (int i = 0; i < N_NEST_OPS; i++) begin
            r = $random(seed);
            nest_strobe(r[0], r[1]);
            if (r[4:2] == 3'd0) verify_all();
        end
        verify_all();

        for (int i = 0; i < N_XFERS; i++) begin
            kind = $unsigned($random(seed)) % NUM_CH;
            setup_random(kind, dma_count_t'($random(seed)));
            do_transfer(kind);
        end

        kind = $unsigned($random(seed)) % NUM_CH;
        setup_random(kind, 16'd1);
        do_transfer(kind);  // Count reaches zero with a done pulse
        do_transfer(kind);  // Wraps to 0xFFFF without one

        for (int i = 0; i < N_PRIO; i++) priority_round();

        @(posedge clk);
        cen <= 1'b0;
        for (int i = 0; i < N_CEN_OPS; i++) begin
            kind = $unsigned($random(seed)) % 3;
            r    = $random(seed);
            cpu_write(kind, r[5:0], $random(seed));
            nest_strobe(r[8], r[9]);
        end
        @(posedge clk);
        cen <= 1'b1;
        verify_all();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/udma_pkg.sv
verilog/udma_regs.sv
verilog/udma_engine.sv
verilog/udma_top.sv
dv/udma_props.sv
dv/udma_tb.sv

//--- Makefile
TOP := udma_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
